// File: gps_config.svh
`ifndef GPS_CONFIG_SVH
`define GPS_CONFIG_SVH

// C/A code structure
`define GPS_CHIPS_PER_CODE   1023   // Chips in one C/A period
`define GPS_SAMPLES_PER_CHIP 2      // Also sets half-chip replica spacing
`define GPS_SAMPLES_PER_CODE (`GPS_CHIPS_PER_CODE * `GPS_SAMPLES_PER_CHIP)

// G1 and G2 register length
`define GPS_LFSR_WIDTH       10     // Stages per LFSR

// Datapath widths
`define GPS_LEVEL_WIDTH      4      // Signed odd level up to +/-7
`define GPS_PHASE_WIDTH      16     // Carrier phase accumulator
`define GPS_POWER_WIDTH      32     // I2+Q2 result word

// Accumulator size
// 2046 samples of magnitude 7 stay well inside 16 signed bits
`define GPS_ACC_WIDTH        16     // Per-replica correlation sum

`endif

// File: gps_pkg.sv
`include "gps_config.svh"

package gps_pkg;

   // Decoded sample level
   // One of +/-1, +/-3, +/-5 or +/-7
   typedef logic signed [`GPS_LEVEL_WIDTH-1:0] sample_level_t;

   // Correlation sum over one code period
   typedef logic signed [`GPS_ACC_WIDTH-1:0] acc_t;

   // Squared magnitude of one I/Q pair
   typedef logic [`GPS_POWER_WIDTH-1:0] power_t;

   // Carrier phase, full turn maps to 2**width
   typedef logic [`GPS_PHASE_WIDTH-1:0] phase_t;

   // Top two carrier phase bits
   typedef enum logic [1:0] {
      QUAD_0   = 2'd0,   // cos +1, sin 0
      QUAD_90  = 2'd1,   // cos 0, sin -1
      QUAD_180 = 2'd2,   // cos -1, sin 0
      QUAD_270 = 2'd3    // cos 0, sin +1
   } quadrant_t;

endpackage

// File: ca_code_gen.sv
`include "gps_config.svh"

module ca_code_gen (
   input  logic       clk,
   input  logic       rst,
   input  logic       sample_valid,   // Advance strobe
   input  logic [4:0] prn,            // PRN minus one
   output logic       chip_early,     // Half chip ahead of prompt
   output logic       chip_prompt,    // Early delayed one strobe
   output logic       chip_late       // Early delayed two strobes
);

   localparam int LFSR_W = `GPS_LFSR_WIDTH;
   localparam int HALF_W = $clog2(`GPS_SAMPLES_PER_CHIP);
   localparam int CHIP_W = $clog2(`GPS_CHIPS_PER_CODE);
   localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`GPS_SAMPLES_PER_CHIP - 1);
   localparam logic [CHIP_W-1:0] CHIP_LAST = CHIP_W'(`GPS_CHIPS_PER_CODE - 1);

   logic [LFSR_W:1]   g1;          // G1 stages, output at top
   logic [LFSR_W:1]   g2;          // G2 stages
   logic [LFSR_W:1]   g2_taps;     // Phase selector mask
   logic [4:0]        prn_q;       // PRN held for the whole period
   logic [HALF_W-1:0] half_cnt;    // Strobes within a chip
   logic [CHIP_W-1:0] chip_cnt;    // Chips within a period
   logic              g1_fb;
   logic              g2_fb;
   logic              code_chip;   // Current C/A chip

   function automatic logic [LFSR_W:1] tap_pair(input int a, input int b);
      logic [LFSR_W:1] mask;
      mask    = '0;
      mask[a] = 1'b1;
      mask[b] = 1'b1;
      return mask;
   endfunction

   // Standard G2 phase selector per satellite
   always_comb begin
      case (prn_q)
         5'd0:  g2_taps = tap_pair(2, 6);
         5'd1:  g2_taps = tap_pair(3, 7);
         5'd2:  g2_taps = tap_pair(4, 8);
         5'd3:  g2_taps = tap_pair(5, 9);
         5'd4:  g2_taps = tap_pair(1, 9);
         5'd5:  g2_taps = tap_pair(2, 10);
         5'd6:  g2_taps = tap_pair(1, 8);
         5'd7:  g2_taps = tap_pair(2, 9);
         5'd8:  g2_taps = tap_pair(3, 10);
         5'd9:  g2_taps = tap_pair(2, 3);
         5'd10: g2_taps = tap_pair(3, 4);
         5'd11: g2_taps = tap_pair(5, 6);
         5'd12: g2_taps = tap_pair(6, 7);
         5'd13: g2_taps = tap_pair(7, 8);
         5'd14: g2_taps = tap_pair(8, 9);
         5'd15: g2_taps = tap_pair(9, 10);
         5'd16: g2_taps = tap_pair(1, 4);
         5'd17: g2_taps = tap_pair(2, 5);
         5'd18: g2_taps = tap_pair(3, 6);
         5'd19: g2_taps = tap_pair(4, 7);
         5'd20: g2_taps = tap_pair(5, 8);
         5'd21: g2_taps = tap_pair(6, 9);
         5'd22: g2_taps = tap_pair(1, 3);
         5'd23: g2_taps = tap_pair(4, 6);
         5'd24: g2_taps = tap_pair(5, 7);
         5'd25: g2_taps = tap_pair(6, 8);
         5'd26: g2_taps = tap_pair(7, 9);
         5'd27: g2_taps = tap_pair(8, 10);
         5'd28: g2_taps = tap_pair(1, 6);
         5'd29: g2_taps = tap_pair(2, 7);
         5'd30: g2_taps = tap_pair(3, 8);
         default: g2_taps = tap_pair(4, 9);   // PRN 32
      endcase
   end

   assign g1_fb     = g1[3] ^ g1[LFSR_W];                         // 1 + x^3 + x^10
   assign g2_fb     = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[LFSR_W];
   assign code_chip = g1[LFSR_W] ^ (^(g2 & g2_taps));             // Gold code output

   always_ff @(posedge clk) begin
      if (rst) begin
         g1          <= '1;              // All-ones start state
         g2          <= '1;
         prn_q       <= prn;             // Satellite picked up at reset
         half_cnt    <= '0;
         chip_cnt    <= '0;
         chip_early  <= 1'b0;            // Delay line starts at chip 0
         chip_prompt <= 1'b0;
         chip_late   <= 1'b0;
      end else if (sample_valid) begin
         chip_early  <= code_chip;       // Registered with the sample
         chip_prompt <= chip_early;
         chip_late   <= chip_prompt;
         if (half_cnt == HALF_LAST) begin
            half_cnt <= '0;
            if (chip_cnt == CHIP_LAST) begin
               chip_cnt <= '0;           // Period wrap
               g1       <= '1;
               g2       <= '1;
               prn_q    <= prn;          // New PRN from next period on
            end else begin
               chip_cnt <= chip_cnt + 1'b1;
               g1       <= {g1[LFSR_W-1:1], g1_fb};
               g2       <= {g2[LFSR_W-1:1], g2_fb};
            end
         end else begin
            half_cnt <= half_cnt + 1'b1;   // First half of the chip
         end
      end
   end

endmodule

// File: sample_decode.sv
`include "gps_config.svh"

module sample_decode (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sample_valid,   // Sample strobe
   input  logic [2:0]            sample_data,    // Sign in bit 2, magnitude below
   input  gps_pkg::phase_t       carrier_inc,    // Phase step per sample
   output logic                  dec_valid,      // One cycle after sample_valid
   output gps_pkg::sample_level_t dec_i,         // In-phase mixed level
   output gps_pkg::sample_level_t dec_q          // Quadrature mixed level
);

   localparam int PW = `GPS_PHASE_WIDTH;

   gps_pkg::phase_t        phase;       // Carrier phase before this sample
   gps_pkg::quadrant_t     quad;        // Top two phase bits
   gps_pkg::sample_level_t mag_level;   // 2m+1
   gps_pkg::sample_level_t level;       // Signed sample level
   logic [1:0]             mag;
   logic                   neg;

   assign neg       = sample_data[2];       // 1 means negative
   assign mag       = sample_data[1:0];
   assign mag_level = {1'b0, mag, 1'b1};    // Odd level 1, 3, 5 or 7
   assign level     = neg ? -mag_level : mag_level;
   assign quad      = gps_pkg::quadrant_t'(phase[PW-1 -: 2]);

   // Phase steps after the sample has been mixed
   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= '0;
      end else if (sample_valid) begin
         phase <= phase + carrier_inc;    // Wraps every full turn
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= sample_valid;       // Same latency as the code chips
      end
   end

   // Four-phase mixer
   always_ff @(posedge clk) begin
      if (sample_valid) begin
         case (quad)
            gps_pkg::QUAD_0: begin
               dec_i <= level;            // cos +1
               dec_q <= '0;
            end
            gps_pkg::QUAD_90: begin
               dec_i <= '0;
               dec_q <= -level;           // sin -1
            end
            gps_pkg::QUAD_180: begin
               dec_i <= -level;           // cos -1
               dec_q <= '0;
            end
            default: begin
               dec_i <= '0;
               dec_q <= level;            // sin +1
            end
         endcase
      end
   end

endmodule

// File: correlator_bank.sv
`include "gps_config.svh"

module correlator_bank (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   dec_valid,     // Mixed sample strobe
   input  gps_pkg::sample_level_t dec_i,
   input  gps_pkg::sample_level_t dec_q,
   input  logic                   chip_early,    // Replicas aligned to dec_valid
   input  logic                   chip_prompt,
   input  logic                   chip_late,
   output logic                   dump_valid,    // One cycle per code period
   output gps_pkg::acc_t          acc_ie,
   output gps_pkg::acc_t          acc_qe,
   output gps_pkg::acc_t          acc_ip,
   output gps_pkg::acc_t          acc_qp,
   output gps_pkg::acc_t          acc_il,
   output gps_pkg::acc_t          acc_ql
);

   localparam int CNT_W = $clog2(`GPS_SAMPLES_PER_CODE);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GPS_SAMPLES_PER_CODE - 1);
   localparam int NACC = 6;   // I and Q for three replicas

   logic [CNT_W-1:0] sample_cnt;    // Samples taken this period
   logic             period_end;    // Last sample of the period
   gps_pkg::acc_t    sum   [NACC];  // Running sums
   gps_pkg::acc_t    prod  [NACC];  // Despread current sample
   gps_pkg::acc_t    total [NACC];  // Sums including current sample

   // Chip 0 passes the level, chip 1 negates it
   function automatic gps_pkg::acc_t despread(input gps_pkg::sample_level_t lvl,
                                             input logic chip);
      gps_pkg::acc_t ext;
      ext = gps_pkg::acc_t'(lvl);    // Sign extend
      return chip ? -ext : ext;
   endfunction

   always_comb begin
      prod[0] = despread(dec_i, chip_early);    // IE
      prod[1] = despread(dec_q, chip_early);    // QE
      prod[2] = despread(dec_i, chip_prompt);   // IP
      prod[3] = despread(dec_q, chip_prompt);   // QP
      prod[4] = despread(dec_i, chip_late);     // IL
      prod[5] = despread(dec_q, chip_late);     // QL
      for (int k = 0; k < NACC; k++) begin
         total[k] = sum[k] + prod[k];
      end
   end

   assign period_end = dec_valid && (sample_cnt == CNT_LAST);

   always_ff @(posedge clk) begin
      if (rst) begin
         sample_cnt <= '0;
         dump_valid <= 1'b0;
         for (int k = 0; k < NACC; k++) begin
            sum[k] <= '0;
         end
      end else begin
         dump_valid <= period_end;            // Single-cycle strobe
         if (dec_valid) begin
            if (period_end) begin
               sample_cnt <= '0;
            end else begin
               sample_cnt <= sample_cnt + 1'b1;
            end
            for (int k = 0; k < NACC; k++) begin
               // Cleared at the dump so the next product starts the period
               sum[k] <= period_end ? '0 : total[k];
            end
         end
      end
   end

   // Totals of the full period, last sample included
   always_ff @(posedge clk) begin
      if (period_end) begin
         acc_ie <= total[0];
         acc_qe <= total[1];
         acc_ip <= total[2];
         acc_qp <= total[3];
         acc_il <= total[4];
         acc_ql <= total[5];
      end
   end

endmodule

// File: i2q2_calc.sv
`include "gps_config.svh"

module i2q2_calc (
   input  logic            clk,
   input  logic            rst,
   input  logic            dump_valid,     // Period totals ready
   input  gps_pkg::acc_t   acc_ie,
   input  gps_pkg::acc_t   acc_qe,
   input  gps_pkg::acc_t   acc_ip,
   input  gps_pkg::acc_t   acc_qp,
   input  gps_pkg::acc_t   acc_il,
   input  gps_pkg::acc_t   acc_ql,
   output logic            i2q2_valid,     // One cycle after dump_valid
   output gps_pkg::power_t i2q2_early,
   output gps_pkg::power_t i2q2_prompt,
   output gps_pkg::power_t i2q2_late,
   output gps_pkg::acc_t   i_prompt,       // Held for the tracking back end
   output gps_pkg::acc_t   q_prompt
);

   // I2+Q2 of one pair
   function automatic gps_pkg::power_t mag_sq(input gps_pkg::acc_t i_val,
                                              input gps_pkg::acc_t q_val);
      logic signed [`GPS_POWER_WIDTH-1:0] i_ext;
      logic signed [`GPS_POWER_WIDTH-1:0] q_ext;
      i_ext = i_val;                          // Sign extended
      q_ext = q_val;
      return gps_pkg::power_t'(i_ext * i_ext + q_ext * q_ext);   // Fits unsigned
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         i2q2_valid  <= 1'b0;
         i2q2_early  <= '0;                   // Zero until the first dump
         i2q2_prompt <= '0;
         i2q2_late   <= '0;
         i_prompt    <= '0;
         q_prompt    <= '0;
      end else begin
         i2q2_valid <= dump_valid;
         if (dump_valid) begin
            i2q2_early  <= mag_sq(acc_ie, acc_qe);
            i2q2_prompt <= mag_sq(acc_ip, acc_qp);
            i2q2_late   <= mag_sq(acc_il, acc_ql);
            i_prompt    <= acc_ip;            // Raw prompt components
            q_prompt    <= acc_qp;
         end
      end
   end

endmodule

// File: gps_channel.sv
module gps_channel (
   input  logic            clk,
   input  logic            rst,
   input  logic            sample_valid,   // Sample strobe, gaps allowed
   input  logic [2:0]      sample_data,    // Sign/magnitude sample
   input  logic [4:0]      prn,            // Satellite minus one
   input  gps_pkg::phase_t carrier_inc,    // Carrier step per sample
   output logic            i2q2_valid,     // Three cycles after last strobe
   output gps_pkg::power_t i2q2_early,
   output gps_pkg::power_t i2q2_prompt,
   output gps_pkg::power_t i2q2_late,
   output gps_pkg::acc_t   i_prompt,
   output gps_pkg::acc_t   q_prompt,
   output logic            ca_bit          // Prompt chip
);

   logic                   dec_valid;
   gps_pkg::sample_level_t dec_i;
   gps_pkg::sample_level_t dec_q;
   logic                   chip_early;
   logic                   chip_prompt;
   logic                   chip_late;
   logic                   dump_valid;
   gps_pkg::acc_t          acc_ie;
   gps_pkg::acc_t          acc_qe;
   gps_pkg::acc_t          acc_ip;
   gps_pkg::acc_t          acc_qp;
   gps_pkg::acc_t          acc_il;
   gps_pkg::acc_t          acc_ql;

   assign ca_bit = chip_prompt;

   sample_decode u_decode (                // Level decode and carrier mix
      .clk(clk), .rst(rst),
      .sample_valid(sample_valid), .sample_data(sample_data),
      .carrier_inc(carrier_inc),
      .dec_valid(dec_valid), .dec_i(dec_i), .dec_q(dec_q));

   ca_code_gen u_code (                    // E/P/L replicas
      .clk(clk), .rst(rst),
      .sample_valid(sample_valid), .prn(prn),
      .chip_early(chip_early), .chip_prompt(chip_prompt), .chip_late(chip_late));

   correlator_bank u_corr (                // Six accumulators per period
      .clk(clk), .rst(rst),
      .dec_valid(dec_valid), .dec_i(dec_i), .dec_q(dec_q),
      .chip_early(chip_early), .chip_prompt(chip_prompt), .chip_late(chip_late),
      .dump_valid(dump_valid),
      .acc_ie(acc_ie), .acc_qe(acc_qe), .acc_ip(acc_ip),
      .acc_qp(acc_qp), .acc_il(acc_il), .acc_ql(acc_ql));

   i2q2_calc u_power (                     // Power and prompt history
      .clk(clk), .rst(rst),
      .dump_valid(dump_valid),
      .acc_ie(acc_ie), .acc_qe(acc_qe), .acc_ip(acc_ip),
      .acc_qp(acc_qp), .acc_il(acc_il), .acc_ql(acc_ql),
      .i2q2_valid(i2q2_valid), .i2q2_early(i2q2_early),
      .i2q2_prompt(i2q2_prompt), .i2q2_late(i2q2_late),
      .i_prompt(i_prompt), .q_prompt(q_prompt));

endmodule

// File: gps_channel_checker.sv
module gps_channel_checker (
   input logic            clk,
   input logic            rst,
   input logic            dump_valid,     // Internal correlator strobe
   input logic            i2q2_valid,
   input gps_pkg::power_t i2q2_prompt,
   input gps_pkg::acc_t   i_prompt,
   input gps_pkg::acc_t   q_prompt
);
   timeunit 1ns;
   timeprecision 100ps;

   int                 fail_cnt;     // Failed assertion count
   logic signed [31:0] i_ext;
   logic signed [31:0] q_ext;
   gps_pkg::power_t    power_ref;    // I2+Q2 of the held prompt pair

   assign i_ext     = i_prompt;
   assign q_ext     = q_prompt;
   assign power_ref = gps_pkg::power_t'(i_ext * i_ext + q_ext * q_ext);

   // Quiet through reset and on the first cycle out of it
   reset_quiet: assert property (@(posedge clk) rst |=> !i2q2_valid && i2q2_prompt == '0)
      else begin
         $error("i2q2_valid or i2q2_prompt not cleared by reset");
         fail_cnt++;
      end

   single_strobe: assert property (@(posedge clk) disable iff (rst) i2q2_valid |=> !i2q2_valid)
      else begin
         $error("i2q2_valid high on two cycles in a row");
         fail_cnt++;
      end

   power_match: assert property (@(posedge clk) disable iff (rst) i2q2_prompt == power_ref)
      else begin
         $error("i2q2_prompt differs from i_prompt squared plus q_prompt squared");
         fail_cnt++;
      end

   dump_to_result: assert property (@(posedge clk) disable iff (rst) dump_valid |=> i2q2_valid)
      else begin
         $error("i2q2_valid missing one cycle after dump_valid");
         fail_cnt++;
      end

endmodule

bind gps_channel gps_channel_checker u_checker (
   .clk(clk), .rst(rst), .dump_valid(dump_valid), .i2q2_valid(i2q2_valid),
   .i2q2_prompt(i2q2_prompt), .i_prompt(i_prompt), .q_prompt(q_prompt));

// File: tb_gps_channel.sv
`include "gps_config.svh"

module tb_gps_channel;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int SPC     = `GPS_SAMPLES_PER_CODE;
   localparam int TIMEOUT = 5 * SPC * 3 + 2000;   // Five tests at up to three cycles per strobe

   logic            clk;
   logic            rst;
   logic            sample_valid;
   logic [2:0]      sample_data;
   logic [4:0]      prn;
   gps_pkg::phase_t carrier_inc;
   logic            i2q2_valid;
   gps_pkg::power_t i2q2_early;
   gps_pkg::power_t i2q2_prompt;
   gps_pkg::power_t i2q2_late;
   gps_pkg::acc_t   i_prompt;
   gps_pkg::acc_t   q_prompt;
   logic            ca_bit;

   bit              g1_seq [1023];              // G1 stage 10 per chip
   bit              g2_seq [1023];
   int              g2_delay [32] = '{5, 6, 7, 8, 17, 18, 139, 140, 141, 251, 252,
                                      254, 255, 256, 257, 258, 469, 470, 471, 472,
                                      473, 474, 509, 512, 513, 514, 515, 516, 859,
                                      860, 861, 862};   // G2 delay in chips per PRN
   int              cos_tab [4] = '{1, 0, -1, 0};   // Quadrant to cos
   int              sin_tab [4] = '{0, -1, 0, 1};
   gps_pkg::phase_t phase_m;                    // Phase before the next sample
   gps_pkg::phase_t inc_sel;                    // Step driven with each strobe
   bit              early_prev;                 // Next sample's prompt chip
   int              prn_sel;                    // PRN index on the prn input
   int              prn_cur;                    // PRN index of the running period
   int              pos;                        // Sample index in the period
   int              acc_i;
   int              acc_q;
   int              cur_kind;                   // 0 plain, 1 constant +1, 2 matched
   int              exp_i_q [$];
   int              exp_q_q [$];
   int              kind_q [$];
   bit              ca_q [$];                   // Prompt chip per strobe
   bit              ca_pending;                 // Strobe taken at the last edge
   logic [31:0]     lcg_state = 32'd46;
   int              cycle_cnt;
   int              err_cnt;
   int              errs_prev;
   int              valid_cnt;
   int              mon_strobes;
   int              last_end_cyc;
   int              test_num;

   gps_channel UUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   function automatic int lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'(lcg_state[30:16]);
   endfunction

   function automatic bit code_chip(input int p, input int chip);
      return g1_seq[chip] ^ g2_seq[(chip + 1023 - g2_delay[p]) % 1023];   // Delayed G2
   endfunction

   function automatic int total_errors();
      return err_cnt + UUT.u_checker.fail_cnt;
   endfunction

   task automatic build_sequences();
      bit [10:1] g1;
      bit [10:1] g2;
      g1 = '1;
      g2 = '1;
      for (int t = 0; t < 1023; t++) begin
         g1_seq[t] = g1[10];
         g2_seq[t] = g2[10];
         g1 = {g1[9:1], g1[3] ^ g1[10]};                                   // 1 + x^3 + x^10
         g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   endtask

   task automatic expect_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      assert (exp == got) else begin
         $display("Mismatch %s expected %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic send_sample(input logic [2:0] data, input int gap);
      int level;
      int quad;
      int desp;
      level = 2 * int'(data[1:0]) + 1;
      if (data[2]) level = -level;
      quad  = phase_m[`GPS_PHASE_WIDTH-1 -: 2];
      desp  = early_prev ? -1 : 1;               // Prompt lags early by one strobe
      acc_i += level * cos_tab[quad] * desp;
      acc_q += level * sin_tab[quad] * desp;
      ca_q.push_back(early_prev);                // ca_bit after this strobe
      early_prev = code_chip(prn_cur, pos / `GPS_SAMPLES_PER_CHIP);
      phase_m += inc_sel;                        // Step after mixing
      @(posedge clk);
      sample_valid <= 1'b1;
      sample_data  <= data;
      prn          <= 5'(prn_sel);
      carrier_inc  <= inc_sel;
      pos++;
      if (pos == SPC) begin
         exp_i_q.push_back(acc_i);
         exp_q_q.push_back(acc_q);
         kind_q.push_back(cur_kind);
         acc_i   = 0;
         acc_q   = 0;
         pos     = 0;
         prn_cur = prn_sel;                      // Loaded with the last strobe
      end
      repeat (gap) begin
         @(posedge clk);
         sample_valid <= 1'b0;
      end
   endtask

   task automatic send_period(input int mode, input int max_gap);
      logic [2:0] data;
      int         gap;
      cur_kind = mode;
      for (int n = 0; n < SPC; n++) begin
         data = 3'(lcg_next());
         if (mode == 1) data = 3'b000;           // Level +1
         if (mode == 2) data[2] = early_prev;    // Sign follows prompt chip
         gap = (max_gap > 0) ? lcg_next() % (max_gap + 1) : 0;
         send_sample(data, gap);
      end
   endtask

   task automatic finish_test(input string name, input int results);
      @(posedge clk);
      sample_valid <= 1'b0;
      while (valid_cnt < results) @(posedge clk);
      test_num++;
      $display("Test %0d %s done with %0d errors", test_num, name, total_errors() - errs_prev);
      errs_prev = total_errors();
   endtask

   // Outputs sampled mid-cycle
   always @(negedge clk) begin : monitor
      int ei;
      int eq;
      int kind;
      bit exp_ca;
      if (!rst) begin
         if (ca_pending) begin
            exp_ca = ca_q.pop_front();
            expect_equal("ca_bit", exp_ca, ca_bit);
         end
         ca_pending = sample_valid;
         if (sample_valid) begin
            if (mon_strobes % SPC == SPC - 1) last_end_cyc = cycle_cnt;
            mon_strobes++;
         end
         if (valid_cnt == 0 && !i2q2_valid) begin
            expect_equal("i2q2_early", 0, i2q2_early);   // Quiet until the first dump
            expect_equal("i2q2_prompt", 0, i2q2_prompt);
            expect_equal("i2q2_late", 0, i2q2_late);
         end
         if (i2q2_valid) begin
            assert (mon_strobes / SPC == valid_cnt + 1 && cycle_cnt - last_end_cyc == 3)
            else begin
               $display("i2q2_valid at cycle %0d is not 3 cycles after a period end", cycle_cnt);
               err_cnt++;
            end
            valid_cnt++;
            if (exp_i_q.size() > 0) begin
               ei   = exp_i_q.pop_front();
               eq   = exp_q_q.pop_front();
               kind = kind_q.pop_front();
               expect_equal("i_prompt", ei, i_prompt);
               expect_equal("q_prompt", eq, q_prompt);
               expect_equal("i2q2_prompt", ei * ei + eq * eq, i2q2_prompt);
               if (kind == 1) expect_equal("i_prompt", -2, i_prompt);   // 512 ones, 511 zeros
               if (kind == 2) begin
                  assert (i2q2_prompt > i2q2_early && i2q2_prompt > i2q2_late) else begin
                     $display("Prompt power %h does not exceed early %h and late %h",
                              i2q2_prompt, i2q2_early, i2q2_late);
                     err_cnt++;
                  end
               end
            end
         end
      end
   end

   initial begin
      wait (cycle_cnt >= TIMEOUT);
      $display("Timeout after %0d cycles with %0d results seen", TIMEOUT, valid_cnt);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      rst          = 1'b1;
      sample_valid = 1'b0;
      sample_data  = 3'd0;
      prn          = 5'd0;
      carrier_inc  = '0;
      phase_m      = '0;
      inc_sel      = '0;
      build_sequences();
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      send_period(0, 0);
      finish_test("reset_quiet", 1);
      send_period(0, 0);
      send_period(0, 2);                 // Up to two idle cycles per strobe
      finish_test("period_timing", 3);
      send_period(1, 0);
      finish_test("balanced_code", 4);
      send_period(2, 1);
      finish_test("matched_signal", 5);
      inc_sel = 16'h4000;                // Quarter turn per sample
      prn_sel = 7;                       // PRN 8 from the next boundary on
      send_period(0, 0);
      send_period(0, 0);
      finish_test("carrier_and_prn", 7);
      $display("Tests run: %0d, errors: %0d", test_num, total_errors());
      if (total_errors() == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: sources.f
+incdir+.
gps_pkg.sv
ca_code_gen.sv
sample_decode.sv
correlator_bank.sv
i2q2_calc.sv
gps_channel.sv
gps_channel_checker.sv
tb_gps_channel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gps_channel
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) gps_config.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
